// ==== common/upload_pkg.sv ====
package upload_pkg;

   localparam int ddr_addr_w = 28;
   localparam int ram_addr_w = 27;
   localparam int hdr_len    = 16;
   localparam int unit_shift = 14;                        // 16 KiB region units

   localparam logic [23:0] magic = "MSX";

   typedef enum logic [2:0] {
      st_idle, st_clean, st_read_hdr, st_check_hdr, st_fill, st_store
   } seq_state_t;

   typedef enum logic [2:0] {
      pat_copy, pat_ones, pat_zeros, pat_alt_lo, pat_alt_hi, pat_half
   } pattern_t;

   typedef struct packed {
      logic                  download;
      logic [5:0]            index;
      logic [ram_addr_w-1:0] addr;
   } ioctl_t;

   typedef struct packed {
      logic                  ce;
      logic [ram_addr_w-1:0] addr;
      logic [7:0]            din;
   } ram_wr_t;

   typedef struct packed {
      logic [10:0] size_units;
      pattern_t    pattern;
      logic        rom;
   } region_t;

endpackage

// ==== common/slot_pkg.sv ====
package slot_pkg;

   localparam int n_blocks = 64;                          // 4 slots x 4 subslots x 4 pages
   localparam int n_refs   = 16;

   typedef enum logic [7:0] {
      mapper_unused,
      mapper_none,
      mapper_ascii8,
      mapper_ascii16,
      mapper_konami,
      mapper_konami_scc
   } mapper_t;

   typedef enum logic [7:0] {
      dev_none,
      dev_fdc
   } mem_device_t;

   typedef enum logic [7:0] {
      id_none,
      id_rom,
      id_ram
   } data_id_t;

   typedef struct packed {
      mapper_t     mapper;
      mem_device_t device;
      logic [3:0]  ref_ram;
      logic [1:0]  offset_ram;
      logic        external;                              // No cartridges, stays 0
   } block_t;

   typedef struct packed {
      logic [26:0] addr;
      logic [15:0] size;                                  // In 16 KiB units
      logic        ro;
   } lookup_ram_t;

   typedef struct packed {
      logic [3:0]  slot_subslot;
      mapper_t     mapper;
      mem_device_t device;
      logic [7:0]  mode;
      logic [7:0]  param;
      data_id_t    data_id;
   } slot_rec_t;

endpackage

// ==== rtl/size_capture.sv ====
`timescale 1ns/1ps

module size_capture (
   input  logic                              clk,
   input  logic                              rst_n,
   input  upload_pkg::ioctl_t                ioctl,
   input  logic                              reload,
   output logic                              load,
   output logic [upload_pkg::ram_addr_w-1:0] stream_size
);

   logic download_q;
   logic download_end;

   // Config stream is download index 1
   assign download_end = download_q && !ioctl.download && ioctl.index == 6'd1;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         download_q  <= 1'b0;
         load        <= 1'b0;
         stream_size <= '0;
      end else begin
         download_q <= ioctl.download;
         load       <= reload;
         if (download_end) begin
            stream_size <= ioctl.addr;
            load        <= 1'b1;
         end
      end
   end

endmodule

// ==== rtl/ddr_byte_reader.sv ====
`timescale 1ns/1ps

module ddr_byte_reader (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              addr_clear,
   input  logic                              hdr_rd,
   input  logic                              fill_rd,
   input  logic                              ddr3_ready,
   input  logic [7:0]                        ddr3_dout,
   output logic [upload_pkg::ddr_addr_w-1:0] ddr3_addr,
   output logic                              ddr3_rd,
   output logic                              byte_valid,
   output logic [7:0]                        rd_byte
);

   logic pending;
   logic data_back;

   // Data is there once ready returns with the strobe already dropped
   assign data_back = pending && !ddr3_rd && ddr3_ready;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         ddr3_addr  <= '0;
         ddr3_rd    <= 1'b0;
         pending    <= 1'b0;
         byte_valid <= 1'b0;
      end else begin
         byte_valid <= 1'b0;
         if (ddr3_rd && ddr3_ready) begin
            ddr3_rd   <= 1'b0;
            ddr3_addr <= ddr3_addr + 1'b1;
         end else if (data_back) begin
            pending    <= 1'b0;
            byte_valid <= 1'b1;
         end else if (!pending && (hdr_rd || fill_rd)) begin
            ddr3_rd <= 1'b1;                              // Peers never ask together
            pending <= 1'b1;
         end
         if (addr_clear) begin
            ddr3_addr <= '0;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (data_back) begin
         rd_byte <= ddr3_dout;
      end
   end

   // A peer asks again only after its byte came back
   a_one_read: assert property (@(posedge clk) disable iff (!rst_n)
      (hdr_rd || fill_rd) |-> !pending && !(hdr_rd && fill_rd));

endmodule

// ==== loader/upload_sequencer.sv ====
`timescale 1ns/1ps

module upload_sequencer (
   input  logic                              clk,
   input  logic                              rst_n,
   input  logic                              load,
   input  logic [upload_pkg::ram_addr_w-1:0] stream_size,
   input  logic [upload_pkg::ddr_addr_w-1:0] ddr3_addr,
   input  logic                              byte_valid,
   input  logic [7:0]                        rd_byte,
   input  logic                              clear_busy,
   input  logic                              fill_done,
   output logic                              hdr_rd,
   output logic                              addr_clear,
   output logic                              clear_start,
   output logic                              fill_start,
   output upload_pkg::region_t               region,
   output logic                              store_en,
   output slot_pkg::slot_rec_t               rec,
   output logic                              reset_rq,
   output logic                              ddr3_request
);

   import upload_pkg::*;
   import slot_pkg::*;

   seq_state_t state;
   logic [7:0] hdr [12];                                  // Bytes 12..15 are not used
   logic [3:0] cnt;
   logic       wait_byte;
   data_id_t   hdr_id;

   assign hdr_id       = data_id_t'(hdr[4]);
   assign reset_rq     = state != st_idle;
   assign ddr3_request = state != st_idle;

   always_ff @(posedge clk) begin
      if (!rst_n) begin
         state       <= st_idle;
         cnt         <= '0;
         wait_byte   <= 1'b0;
         hdr_rd      <= 1'b0;
         addr_clear  <= 1'b0;
         clear_start <= 1'b0;
         fill_start  <= 1'b0;
         store_en    <= 1'b0;
      end else begin
         hdr_rd      <= 1'b0;
         addr_clear  <= 1'b0;
         clear_start <= 1'b0;
         fill_start  <= 1'b0;
         store_en    <= 1'b0;
         if (load) begin
            state       <= st_clean;
            cnt         <= '0;
            wait_byte   <= 1'b0;
            addr_clear  <= 1'b1;
            clear_start <= 1'b1;
         end else begin
            case (state)
               st_clean: begin
                  if (!clear_start && !clear_busy) begin
                     state <= st_read_hdr;
                  end
               end
               st_read_hdr: begin
                  if (wait_byte) begin
                     if (byte_valid) begin
                        wait_byte <= 1'b0;
                        cnt       <= cnt + 1'b1;
                        if (cnt < 4'd12) begin
                           hdr[cnt] <= rd_byte;
                        end
                        if (cnt == 4'(hdr_len - 1)) begin
                           state <= st_check_hdr;
                        end
                     end
                  end else if (cnt == '0 && ddr3_addr >= ddr_addr_w'(stream_size)) begin
                     state <= st_idle;                    // Stream exhausted
                  end else begin
                     hdr_rd    <= 1'b1;
                     wait_byte <= 1'b1;
                  end
               end
               st_check_hdr: begin
                  if ({hdr[0], hdr[1], hdr[2]} != magic) begin
                     state <= st_idle;
                  end else if (hdr[3][7:4] != 4'd4) begin
                     state <= st_read_hdr;                // Not an internal slot, skip
                  end else begin
                     rec.slot_subslot  <= hdr[3][3:0];
                     rec.device        <= mem_device_t'(hdr[4]);
                     rec.data_id       <= hdr_id;
                     rec.mapper        <= mapper_t'(hdr[8]);
                     rec.mode          <= hdr[9];
                     rec.param         <= hdr[10];
                     region.size_units <= {hdr[5][2:0], hdr[6]};
                     region.rom        <= hdr_id == id_rom;
                     region.pattern    <= hdr_id == id_rom ? pat_copy : pattern_t'(hdr[11][2:0]);
                     fill_start        <= 1'b1;
                     state             <= st_fill;
                  end
               end
               st_fill: begin
                  if (fill_done) begin
                     store_en <= 1'b1;
                     state    <= st_store;
                  end
               end
               st_store: state <= st_read_hdr;
               default: state <= st_idle;
            endcase
         end
      end
   end

   // Fill engine answers only while a region is outstanding
   a_done_in_fill: assert property (@(posedge clk) disable iff (!rst_n)
      fill_done |-> state == st_fill);

endmodule

// ==== loader/region_fill.sv ====
`timescale 1ns/1ps

module region_fill (
   input  logic                  clk,
   input  logic                  rst_n,
   input  logic                  load,
   input  logic                  fill_start,
   input  upload_pkg::region_t   region,
   input  logic                  byte_valid,
   input  logic [7:0]            rd_byte,
   input  logic                  sdram_ready,
   output logic                  fill_rd,
   output upload_pkg::ram_wr_t   ram,
   output logic                  sdram_rq,
   output logic                  fill_done,
   output logic [3:0]            ref_ram,
   output slot_pkg::lookup_ram_t lookup_ram [slot_pkg::n_refs]
);

   import upload_pkg::*;

   pattern_t    pattern;
   logic        active;
   logic        waiting;
   logic        got_byte;
   logic        ref_add;
   logic [24:0] remaining;
   logic [8:0]  offset;                                   // Byte offset modulo 512
   logic [7:0]  data_q;
   logic [7:0]  fill_byte;
   logic [3:0]  next_ref;

   // Index moves on only when the previous region wrote an entry
   assign next_ref = ref_ram + 4'(ref_add);

   always_comb begin
      case (pattern)
         pat_copy:   fill_byte = data_q;
         pat_ones:   fill_byte = 8'hff;
         pat_zeros:  fill_byte = 8'h00;
         pat_alt_lo: fill_byte = {8{offset[8] ~^ offset[1]}};
         pat_alt_hi: fill_byte = {8{offset[8] ~^ offset[0]}};
         pat_half:   fill_byte = {8{offset[7]}};
         default:    fill_byte = 8'hff;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rst_n || load) begin
         active   <= 1'b0;
         waiting  <= 1'b0;
         got_byte <= 1'b0;
         ref_add  <= 1'b0;
         ref_ram  <= '0;
         fill_rd  <= 1'b0;
         sdram_rq <= 1'b0;
         ram.ce   <= 1'b0;
         ram.addr <= '0;
         fill_done <= 1'b0;
      end else begin
         fill_rd   <= 1'b0;
         fill_done <= 1'b0;
         if (fill_start) begin
            pattern <= region.pattern;
            offset  <= '0;
            if (region.size_units == '0) begin
               fill_done <= 1'b1;                         // Empty region, no entry
            end else begin
               ref_ram              <= next_ref;
               ref_add              <= 1'b1;
               lookup_ram[next_ref] <= '{addr: ram.addr, size: 16'(region.size_units),
                                         ro: region.rom};
               remaining            <= 25'(region.size_units) << unit_shift;
               active               <= 1'b1;
               sdram_rq             <= 1'b1;
            end
         end else if (active) begin
            if (ram.ce) begin
               ram.ce    <= 1'b0;
               ram.addr  <= ram.addr + 1'b1;
               offset    <= offset + 1'b1;
               remaining <= remaining - 1'b1;
               if (remaining == 25'd1) begin
                  active    <= 1'b0;
                  sdram_rq  <= 1'b0;
                  fill_done <= 1'b1;
               end
            end else if (pattern != pat_copy || got_byte) begin
               if (sdram_ready) begin
                  ram.ce   <= 1'b1;
                  ram.din  <= fill_byte;
                  got_byte <= 1'b0;
               end
            end else if (!waiting) begin
               fill_rd <= 1'b1;
               waiting <= 1'b1;
            end else if (byte_valid) begin
               data_q   <= rd_byte;
               got_byte <= 1'b1;
               waiting  <= 1'b0;
            end
         end
      end
   end

endmodule

// ==== loader/slot_layout_store.sv ====
`timescale 1ns/1ps

module slot_layout_store (
   input  logic                clk,
   input  logic                rst_n,
   input  logic                clear_start,
   output logic                clear_busy,
   input  logic                store_en,
   input  slot_pkg::slot_rec_t rec,
   input  logic [3:0]          ref_ram,
   output slot_pkg::block_t    slot_layout [slot_pkg::n_blocks]
);

   import slot_pkg::*;

   logic [5:0] clr_idx;
   logic [3:0] ref_sel;

   assign ref_sel = rec.data_id == id_none ? 4'd0 : ref_ram;

   always_ff @(posedge clk) begin
      block_t     sib;
      logic [5:0] blk;
      logic [1:0] md;
      logic [1:0] prm;
      if (!rst_n) begin
         clear_busy <= 1'b0;
         clr_idx    <= '0;
      end else if (clear_start) begin
         clear_busy <= 1'b1;
         clr_idx    <= '0;
      end else if (clear_busy) begin
         slot_layout[clr_idx] <= '{mapper: mapper_unused, device: dev_none, default: '0};
         clr_idx              <= clr_idx + 1'b1;
         if (clr_idx == 6'(n_blocks - 1)) begin
            clear_busy <= 1'b0;
         end
      end else if (store_en) begin
         for (int k = 0; k < 4; k++) begin
            md  = rec.mode[2*k +: 2];
            prm = rec.param[2*k +: 2];
            blk = {rec.slot_subslot, 2'(k)};
            sib = slot_layout[{rec.slot_subslot, prm}];  // Sibling page, old contents
            case (md)
               2'd1: begin
                  slot_layout[blk] <= '{mapper: sib.mapper, device: dev_none,
                                        ref_ram: sib.ref_ram, offset_ram: sib.offset_ram,
                                        external: 1'b0};
               end
               2'd2, 2'd3: begin
                  slot_layout[blk] <= '{mapper: md == 2'd2 ? rec.mapper : mapper_unused,
                                        device: rec.device, ref_ram: ref_sel,
                                        offset_ram: prm, external: 1'b0};
               end
               default: ;                                 // Page left as it is
            endcase
         end
      end
   end

   a_store_not_clearing: assert property (@(posedge clk) disable iff (!rst_n)
      store_en |-> !clear_busy);

endmodule

// ==== rtl/memory_upload.sv ====
`timescale 1ns/1ps

module memory_upload (
   input  logic                              clk,
   input  logic                              rst_n,
   input  upload_pkg::ioctl_t                ioctl,
   input  logic                              reload,
   output logic [upload_pkg::ddr_addr_w-1:0] ddr3_addr,
   output logic                              ddr3_rd,
   input  logic [7:0]                        ddr3_dout,
   input  logic                              ddr3_ready,
   output logic                              ddr3_request,
   output upload_pkg::ram_wr_t               ram,
   input  logic                              sdram_ready,
   output logic                              sdram_rq,
   output logic                              reset_rq,
   output slot_pkg::block_t                  slot_layout [slot_pkg::n_blocks],
   output slot_pkg::lookup_ram_t             lookup_ram [slot_pkg::n_refs]
);

   import upload_pkg::*;
   import slot_pkg::*;

   logic                  load;
   logic [ram_addr_w-1:0] stream_size;
   logic                  addr_clear;
   logic                  hdr_rd;
   logic                  fill_rd;
   logic                  byte_valid;
   logic [7:0]            rd_byte;
   logic                  clear_start;
   logic                  clear_busy;
   logic                  fill_start;
   logic                  fill_done;
   logic                  store_en;
   logic [3:0]            ref_ram;
   region_t               region;
   slot_rec_t             rec;

   size_capture u_size_capture (.*);

   ddr_byte_reader u_ddr_byte_reader (.*);

   upload_sequencer u_upload_sequencer (.*);

   region_fill u_region_fill (.*);

   slot_layout_store u_slot_layout_store (.*);

endmodule

// ==== sim/tb_tasks.svh ====
function automatic logic [31:0] lfsr_step(input logic [31:0] s);
   return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};         // x^32 + x^22 + x^2 + x + 1
endfunction

task automatic random_byte(output logic [7:0] b);
   for (int i = 0; i < 8; i++) begin
      data_lfsr = lfsr_step(data_lfsr);
      b         = {b[6:0], data_lfsr[0]};
   end
endtask

task automatic check_value(input string name, input logic [31:0] got,
                           input logic [31:0] expected);
   checks++;
   if (got !== expected) begin
      errors++;
      $display("MISMATCH %s: got 0x%h, expected 0x%h", name, got, expected);
   end
endtask

function automatic logic [7:0] pattern_byte(input pattern_t pat, input int offset);
   logic [8:0] o;
   logic       fill;
   o = offset[8:0];
   case (pat)
      pat_ones:   fill = 1'b1;
      pat_alt_lo: fill = o[8] ? o[1] : !o[1];
      pat_alt_hi: fill = o[8] ? o[0] : !o[0];
      pat_half:   fill = o[7];
      default:    fill = 1'b0;
   endcase
   return {8{fill}};
endfunction

task automatic put_header(input int at, input logic [23:0] tag, input logic [3:0] slot,
                          input data_id_t id, input logic [10:0] size, input mapper_t mapper,
                          input logic [7:0] mode, input logic [7:0] param, input pattern_t pat);
   for (int i = 0; i < 16; i++) begin
      ddr_mem[at + i] = 8'h00;
   end
   {ddr_mem[at], ddr_mem[at + 1], ddr_mem[at + 2]} = tag;
   ddr_mem[at + 3]  = {4'h4, slot};                       // Internal slot record
   ddr_mem[at + 4]  = id;
   ddr_mem[at + 5]  = {5'b0, size[10:8]};
   ddr_mem[at + 6]  = size[7:0];
   ddr_mem[at + 8]  = mapper;
   ddr_mem[at + 9]  = mode;
   ddr_mem[at + 10] = param;
   ddr_mem[at + 11] = 8'(pat);
endtask

task automatic pulse_download(input logic [5:0] idx, input int size);
   @(posedge clk);
   ioctl <= '{download: 1'b1, index: idx, addr: 27'(size)};
   repeat (4) @(posedge clk);
   ioctl.download <= 1'b0;
   @(posedge clk);
endtask

task automatic wait_loader_done();
   @(negedge clk);
   while (!reset_rq) @(negedge clk);
   while (reset_rq) @(negedge clk);
endtask

task automatic check_block(input int blk, input logic [7:0] mapper, input logic [7:0] device,
                           input logic [3:0] ref_idx, input logic [1:0] offset);
   check_value($sformatf("slot_layout[%0d].mapper", blk), slot_layout[blk].mapper, mapper);
   check_value($sformatf("slot_layout[%0d].device", blk), slot_layout[blk].device, device);
   check_value($sformatf("slot_layout[%0d].ref_ram", blk), slot_layout[blk].ref_ram, ref_idx);
   check_value($sformatf("slot_layout[%0d].offset_ram", blk), slot_layout[blk].offset_ram,
               offset);
endtask

task automatic check_lookup(input int idx, input logic [26:0] addr, input logic [15:0] size,
                            input logic ro);
   check_value($sformatf("lookup_ram[%0d].addr", idx), lookup_ram[idx].addr, addr);
   check_value($sformatf("lookup_ram[%0d].size", idx), lookup_ram[idx].size, size);
   check_value($sformatf("lookup_ram[%0d].ro", idx), lookup_ram[idx].ro, ro);
endtask

task automatic test_reset_idle();
   logic seen;
   seen = 1'b0;
   check_value("reset_rq", reset_rq, 0);
   check_value("ddr3_rd", ddr3_rd, 0);
   check_value("ram.ce", ram.ce, 0);
   check_value("sdram_rq", sdram_rq, 0);
   check_value("ddr3_request", ddr3_request, 0);
   pulse_download(6'd2, 32);                              // Not the config stream
   repeat (20) begin
      @(negedge clk);
      seen = seen | reset_rq;
   end
   check_value("reset_rq", seen, 0);
endtask

task automatic test_rom_copy();
   logic [7:0] b;
   put_header(0, "MSX", 4'h0, id_rom, 11'd1, mapper_none, 8'h02, 8'h00, pat_ones);
   for (int i = 0; i < region_bytes; i++) begin
      random_byte(b);
      ddr_mem[16 + i] = b;
   end
   pulse_download(6'd1, 16 + region_bytes);
   wait_loader_done();
   for (int i = 0; i < region_bytes; i++) begin
      check_value($sformatf("sdram[%0d]", i), sdram_mem[i], ddr_mem[16 + i]);
   end
   check_lookup(0, 27'd0, 16'd1, 1'b1);
endtask

task automatic test_pattern_fill();
   pattern_t pats [3];
   pats = '{pat_ones, pat_alt_lo, pat_half};
   for (int r = 0; r < 3; r++) begin
      put_header(16 * r, "MSX", 4'(4 + r), id_ram, 11'd1, mapper_none, 8'h00, 8'h00, pats[r]);
   end
   pulse_download(6'd1, 48);
   wait_loader_done();
   for (int r = 0; r < 3; r++) begin
      for (int o = 0; o < region_bytes; o++) begin
         check_value($sformatf("sdram[%0d]", r * region_bytes + o),
                     sdram_mem[r * region_bytes + o], pattern_byte(pats[r], o));
      end
      check_lookup(r, 27'(r * region_bytes), 16'd1, 1'b0);
   end
endtask

task automatic test_slot_modes();
   put_header(0, "MSX", 4'h2, id_ram, 11'd1, mapper_konami, 8'h02, 8'h01, pat_ones);
   put_header(16, "MSX", 4'h2, id_ram, 11'd1, mapper_ascii8, 8'h36, 8'h72, pat_zeros);
   pulse_download(6'd1, 32);
   wait_loader_done();
   // Device shares header byte 4 with data_id
   for (int blk = 0; blk < n_blocks; blk++) begin
      case (blk)
         8:       check_block(blk, mapper_ascii8, id_ram, 4'd1, 2'd2);
         9:       check_block(blk, mapper_konami, dev_none, 4'd0, 2'd1);  // Page 0 from record one
         10:      check_block(blk, mapper_unused, id_ram, 4'd1, 2'd3);
         default: check_block(blk, mapper_unused, dev_none, 4'd0, 2'd0);
      endcase
   end
endtask

task automatic test_termination();
   lookup_ram_t entry0;
   int          writes;
   entry0 = lookup_ram[0];
   writes = write_count;
   put_header(0, "MSX", 4'h1, id_none, 11'd0, mapper_none, 8'h02, 8'h03, pat_zeros);
   put_header(16, "MSY", 4'h2, id_ram, 11'd1, mapper_none, 8'h02, 8'h00, pat_ones);
   put_header(32, "MSX", 4'h3, id_none, 11'd0, mapper_konami, 8'h02, 8'h01, pat_zeros);
   pulse_download(6'd1, 48);
   wait_loader_done();
   check_value("ddr3_addr", ddr3_addr, 32);
   check_block(4, mapper_none, dev_none, 4'd0, 2'd3);
   check_block(8, mapper_unused, dev_none, 4'd0, 2'd0);
   check_block(12, mapper_unused, dev_none, 4'd0, 2'd0);  // Behind the bad header
   check_value("write_count", write_count, writes);
   check_lookup(0, entry0.addr, entry0.size, entry0.ro);
endtask

// ==== sim/tb_memory_upload.sv ====
`timescale 1ns/1ps

module tb_memory_upload;

   import upload_pkg::*;
   import slot_pkg::*;

   localparam int region_bytes   = 16384;
   localparam int stream_bytes   = 16400 + 48 + 32 + 48;
   localparam int written_bytes  = 6 * region_bytes;
   localparam int timeout_cycles = (stream_bytes + written_bytes) * 8 + 5000;

   logic                  clk;
   logic                  rst_n;
   ioctl_t                ioctl;
   logic                  reload;
   logic [ddr_addr_w-1:0] ddr3_addr;
   logic                  ddr3_rd;
   logic [7:0]            ddr3_dout = 8'h00;
   logic                  ddr3_ready = 1'b0;
   logic                  ddr3_request;
   ram_wr_t               ram;
   logic                  sdram_ready = 1'b0;
   logic                  sdram_rq;
   logic                  reset_rq;
   block_t                slot_layout [n_blocks];
   lookup_ram_t           lookup_ram [n_refs];

   logic [7:0]  ddr_mem [32768];
   logic [7:0]  sdram_mem [131072];
   logic [31:0] ready_lfsr = 32'h086b_e43b;
   logic [31:0] data_lfsr = 32'h086b_e43b;
   int          write_count = 0;
   int          cycle_count = 0;
   int          checks = 0;
   int          errors = 0;

   memory_upload uut (.*);

   `include "tb_tasks.svh"

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   // DDR3 byte is latched when the read is accepted
   always @(posedge clk) begin
      if (ddr3_rd) begin
         check_value("ddr3_request", ddr3_request, 1);
      end
      if (ddr3_rd && ddr3_ready) begin
         ddr3_dout <= ddr_mem[ddr3_addr[14:0]];
      end
   end

   always @(posedge clk) begin
      logic ddr_bit;
      ready_lfsr = lfsr_step(ready_lfsr);
      ddr_bit    = ready_lfsr[0];
      ready_lfsr = lfsr_step(ready_lfsr);
      ddr3_ready <= ddr_bit | ready_lfsr[0];              // Ready about 3 cycles in 4
      ready_lfsr = lfsr_step(ready_lfsr);
      sdram_ready <= ready_lfsr[0];
   end

   always @(posedge clk) begin
      if (ram.ce) begin
         check_value("sdram_rq", sdram_rq, 1);
         sdram_mem[ram.addr[16:0]] <= ram.din;
         write_count               <= write_count + 1;
      end
   end

   always @(posedge clk) begin
      cycle_count <= cycle_count + 1;
      if (cycle_count >= timeout_cycles) begin
         $display("Timeout: the loader did not finish within %0d cycles", timeout_cycles);
         $display("TESTS FAILED");
         $finish;
      end
   end

   initial begin
      rst_n  = 1'b0;
      ioctl  = '0;
      reload = 1'b0;
      for (int a = 0; a < 131072; a++) begin
         sdram_mem[a] = 8'(a ^ (a >> 8) ^ (a >> 16)) ^ 8'h5a;
      end
      repeat (16) @(posedge clk);
      rst_n <= 1'b1;
      @(negedge clk);
      test_reset_idle();
      test_rom_copy();
      test_pattern_fill();
      test_slot_modes();
      test_termination();
      $display("Checks: %0d, errors: %0d", checks, errors);
      if (errors == 0) begin
         $display("TESTS PASSED");
      end else begin
         $display("TESTS FAILED");
      end
      $finish;
   end

endmodule

// ==== all.f ====
+incdir+sim
common/upload_pkg.sv
common/slot_pkg.sv
rtl/size_capture.sv
rtl/ddr_byte_reader.sv
loader/upload_sequencer.sv
loader/region_fill.sv
loader/slot_layout_store.sv
rtl/memory_upload.sv
sim/tb_memory_upload.sv

// ==== Makefile ====
.PHONY: all lint clean

all:
	verilator --binary --timing --assert -Wno-fatal -f all.f --top-module tb_memory_upload \
		--Mdir obj_dir -o tb_memory_upload
	./obj_dir/tb_memory_upload > sim.log; cat sim.log
	grep -q "TESTS PASSED" sim.log
	! grep -q "TESTS FAILED" sim.log

lint:
	verilator --lint-only -Wall --timing -f all.f --top-module memory_upload

clean:
	rm -rf obj_dir sim.log
